/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_apu
FILELIST = build.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator output goes to the terminal; the status comes from grep.
run: compile
	./$(BIN) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* apu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_chk (
    input logic                                system_clock,
    input logic                                arst_n,
    input logic [apu_timing_pkg::SAMPLE_W-1:0] sample,
    input logic [apu_reg_pkg::CH_N-1:0]        ch_enable,
    input logic                                sq_trig,
    input logic                                nz_trig,
    input logic                                len_tick,
    input logic                                sweep_tick,
    input logic                                env_tick
);
    int fail_cnt = 0;  // Failed assertion count.

    sample_max: assert property (@(posedge system_clock) disable iff (!arst_n)
        sample <= 8'd240)
        else begin
            $error("sample above 240");
            fail_cnt = fail_cnt + 1;
        end

    sq_trig_pulse: assert property (@(posedge system_clock) disable iff (!arst_n)
        sq_trig |=> !sq_trig)
        else begin
            $error("sq_trig longer than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    nz_trig_pulse: assert property (@(posedge system_clock) disable iff (!arst_n)
        nz_trig |=> !nz_trig)
        else begin
            $error("nz_trig longer than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    no_tick_in_reset: assert property (@(posedge system_clock)
        !arst_n |-> !(len_tick || sweep_tick || env_tick))
        else begin
            $error("frame tick during reset");
            fail_cnt = fail_cnt + 1;
        end

    // Mixer output lags the enables by one register.
    silent_when_off: assert property (@(posedge system_clock) disable iff (!arst_n)
        (ch_enable == '0) |=> (sample == '0))
        else begin
            $error("sample not 0 with both channels disabled");
            fail_cnt = fail_cnt + 1;
        end

endmodule

`default_nettype wire

/* apu_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_mixer (
    input  logic                                 system_clock,
    input  logic                                 arst_n,
    input  logic [apu_timing_pkg::LEVEL_W-1:0]   sq_level,
    input  logic [apu_timing_pkg::LEVEL_W-1:0]   nz_level,
    input  logic [apu_reg_pkg::CH_N-1:0]         ch_enable,
    input  logic [apu_reg_pkg::MVOL_W-1:0]       master_vol,
    output logic [apu_timing_pkg::SAMPLE_W-1:0]  sample
);
    import apu_reg_pkg::*;
    import apu_timing_pkg::*;

    logic [LEVEL_W:0]  sum;    // At most 30.
    logic [MVOL_W:0]   scale;  // 1 to 8.
    logic [SAMPLE_W-1:0] mix;

    assign sum   = (ch_enable[0] ? {1'b0, sq_level} : '0)
                 + (ch_enable[1] ? {1'b0, nz_level} : '0);
    assign scale = {1'b0, master_vol} + 1'b1;
    assign mix   = SAMPLE_W'(sum) * SAMPLE_W'(scale);

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            sample <= '0;
        end else begin
            sample <= mix;
        end
    end

endmodule

`default_nettype wire

/* apu_reg_pkg.sv */
`default_nettype none

package apu_reg_pkg;

    localparam int ADDR_W = 4;
    localparam int DATA_W = 8;

    localparam logic [ADDR_W-1:0] ADDR_NR10 = 4'd0;   // Sweep.
    localparam logic [ADDR_W-1:0] ADDR_NR11 = 4'd1;   // Duty and length.
    localparam logic [ADDR_W-1:0] ADDR_NR12 = 4'd2;   // Square envelope.
    localparam logic [ADDR_W-1:0] ADDR_NR13 = 4'd3;   // Frequency low.
    localparam logic [ADDR_W-1:0] ADDR_NR14 = 4'd4;   // Trigger, length enable, freq high.
    localparam logic [ADDR_W-1:0] ADDR_NR41 = 4'd8;   // Noise length.
    localparam logic [ADDR_W-1:0] ADDR_NR42 = 4'd9;   // Noise envelope.
    localparam logic [ADDR_W-1:0] ADDR_NR43 = 4'd10;  // Noise clock.
    localparam logic [ADDR_W-1:0] ADDR_NR44 = 4'd11;  // Noise trigger.
    localparam logic [ADDR_W-1:0] ADDR_NR50 = 4'd12;  // Master volume.
    localparam logic [ADDR_W-1:0] ADDR_NR51 = 4'd13;  // Channel enables.

    localparam int FREQ_W     = 11;
    localparam int LEN_W      = 6;
    localparam int VOL_W      = 4;
    localparam int SWP_W      = 3;  // Sweep period and shift.
    localparam int DUTY_W     = 2;
    localparam int ENV_PER_W  = 3;
    localparam int NZ_SHIFT_W = 4;
    localparam int NZ_DIV_W   = 3;
    localparam int MVOL_W     = 3;
    localparam int CH_N       = 2;

endpackage

`default_nettype wire

/* apu_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_regs (
    input  logic                                  system_clock,
    input  logic                                  arst_n,
    input  logic                                  wr_en,
    input  logic [apu_reg_pkg::ADDR_W-1:0]        wr_addr,
    input  logic [apu_reg_pkg::DATA_W-1:0]        wr_data,
    output logic [apu_reg_pkg::SWP_W-1:0]         sweep_period,
    output logic                                  sweep_down,
    output logic [apu_reg_pkg::SWP_W-1:0]         sweep_shift,
    output logic [apu_reg_pkg::DUTY_W-1:0]        sq_duty,
    output logic [apu_reg_pkg::LEN_W-1:0]         sq_len_load,
    output logic [apu_reg_pkg::VOL_W-1:0]         sq_env_init,
    output logic                                  sq_env_up,
    output logic [apu_reg_pkg::ENV_PER_W-1:0]     sq_env_period,
    output logic [apu_reg_pkg::FREQ_W-1:0]        sq_freq,
    output logic                                  sq_len_en,
    output logic [apu_reg_pkg::LEN_W-1:0]         nz_len_load,
    output logic                                  nz_len_en,
    output logic [apu_reg_pkg::VOL_W-1:0]         nz_env_init,
    output logic                                  nz_env_up,
    output logic [apu_reg_pkg::ENV_PER_W-1:0]     nz_env_period,
    output logic [apu_reg_pkg::NZ_SHIFT_W-1:0]    nz_shift,
    output logic                                  nz_width7,
    output logic [apu_reg_pkg::NZ_DIV_W-1:0]      nz_div,
    output logic [apu_reg_pkg::MVOL_W-1:0]        master_vol,
    output logic [apu_reg_pkg::CH_N-1:0]          ch_enable,
    output logic                                  sq_trig,
    output logic                                  nz_trig
);
    import apu_reg_pkg::*;

    logic trig_wr;

    assign trig_wr = wr_en && wr_data[DATA_W-1];

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            {sweep_period, sweep_down, sweep_shift} <= '0;
            {sq_duty, sq_len_load, sq_freq, sq_len_en} <= '0;
            {sq_env_init, sq_env_up, sq_env_period} <= '0;
            {nz_len_load, nz_len_en, nz_shift, nz_width7, nz_div} <= '0;
            {nz_env_init, nz_env_up, nz_env_period} <= '0;
            master_vol <= '0;
            ch_enable  <= '0;
            sq_trig    <= 1'b0;
            nz_trig    <= 1'b0;
        end else begin
            sq_trig <= trig_wr && (wr_addr == ADDR_NR14);  // Pulse, not stored.
            nz_trig <= trig_wr && (wr_addr == ADDR_NR44);
            if (wr_en) begin
                case (wr_addr)
                    ADDR_NR10: {sweep_period, sweep_down, sweep_shift} <= wr_data[6:0];
                    ADDR_NR11: {sq_duty, sq_len_load} <= wr_data;
                    ADDR_NR12: {sq_env_init, sq_env_up, sq_env_period} <= wr_data;
                    ADDR_NR13: sq_freq[7:0] <= wr_data;
                    ADDR_NR14: begin
                        sq_len_en     <= wr_data[6];
                        sq_freq[10:8] <= wr_data[2:0];
                    end
                    ADDR_NR41: nz_len_load <= wr_data[LEN_W-1:0];
                    ADDR_NR42: {nz_env_init, nz_env_up, nz_env_period} <= wr_data;
                    ADDR_NR43: {nz_shift, nz_width7, nz_div} <= wr_data;
                    ADDR_NR44: nz_len_en <= wr_data[6];
                    ADDR_NR50: master_vol <= wr_data[MVOL_W-1:0];
                    ADDR_NR51: ch_enable <= wr_data[CH_N-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* apu_timing_pkg.sv */
`default_nettype none

package apu_timing_pkg;

    localparam int SEQ_DIV   = 64;  // Kept short for simulation.
    localparam int SEQ_STEPS = 8;
    localparam int DIV_W     = $clog2(SEQ_DIV);
    localparam int STEP_W    = $clog2(SEQ_STEPS);

    // One bit per step, bit 0 is step 0.
    localparam logic [SEQ_STEPS-1:0] LEN_STEPS   = 8'b0101_0101;
    localparam logic [SEQ_STEPS-1:0] SWEEP_STEPS = 8'b0100_0100;
    localparam logic [SEQ_STEPS-1:0] ENV_STEPS   = 8'b1000_0000;

    localparam int SAMPLE_W = 8;
    localparam int LEVEL_W  = 4;

    // Noise timer must hold 112 << 15.
    localparam int NZ_TMR_W = 22;

endpackage

`default_nettype wire

/* apu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_top (
    input  logic                                 system_clock,
    input  logic                                 arst_n,
    input  logic                                 wr_en,
    input  logic [apu_reg_pkg::ADDR_W-1:0]       wr_addr,
    input  logic [apu_reg_pkg::DATA_W-1:0]       wr_data,
    output logic [apu_timing_pkg::SAMPLE_W-1:0]  sample,
    output logic                                 sq_on,
    output logic                                 nz_on
);
    import apu_reg_pkg::*;
    import apu_timing_pkg::*;

    logic [SWP_W-1:0]      sweep_period, sweep_shift;
    logic                  sweep_down;
    logic [DUTY_W-1:0]     sq_duty;
    logic [LEN_W-1:0]      sq_len_load, nz_len_load;
    logic [VOL_W-1:0]      sq_env_init, nz_env_init;
    logic                  sq_env_up, nz_env_up, sq_len_en, nz_len_en;
    logic [ENV_PER_W-1:0]  sq_env_period, nz_env_period;
    logic [FREQ_W-1:0]     sq_freq;
    logic [NZ_SHIFT_W-1:0] nz_shift;
    logic                  nz_width7;
    logic [NZ_DIV_W-1:0]   nz_div;
    logic [MVOL_W-1:0]     master_vol;
    logic [CH_N-1:0]       ch_enable;
    logic                  sq_trig, nz_trig;
    logic                  len_tick, sweep_tick, env_tick;
    logic [LEVEL_W-1:0]    sq_level, nz_level;

    apu_regs regs_i (.*);

    frame_sequencer seq_i (.*);

    square_channel sq_i (
        .system_clock(system_clock), .arst_n(arst_n), .trig(sq_trig),
        .len_tick(len_tick), .sweep_tick(sweep_tick), .env_tick(env_tick),
        .freq(sq_freq), .duty(sq_duty), .sweep_period(sweep_period),
        .sweep_down(sweep_down), .sweep_shift(sweep_shift), .len_load(sq_len_load),
        .len_en(sq_len_en), .env_init(sq_env_init), .env_up(sq_env_up),
        .env_period(sq_env_period), .level(sq_level), .on(sq_on)
    );

    noise_channel nz_i (
        .system_clock(system_clock), .arst_n(arst_n), .trig(nz_trig),
        .len_tick(len_tick), .env_tick(env_tick), .shift(nz_shift),
        .width7(nz_width7), .div(nz_div), .len_load(nz_len_load),
        .len_en(nz_len_en), .env_init(nz_env_init), .env_up(nz_env_up),
        .env_period(nz_env_period), .level(nz_level), .on(nz_on)
    );

    apu_mixer mix_i (.*);

endmodule

`default_nettype wire

/* build.f */
apu_reg_pkg.sv
apu_timing_pkg.sv
apu_regs.sv
frame_sequencer.sv
length_envelope.sv
square_channel.sv
noise_channel.sv
apu_mixer.sv
apu_top.sv
apu_chk.sv
tb_apu.sv

/* frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input  logic system_clock,
    input  logic arst_n,
    output logic len_tick,
    output logic sweep_tick,
    output logic env_tick
);
    import apu_timing_pkg::*;

    logic [DIV_W-1:0]  div_cnt;
    logic [STEP_W-1:0] step;
    logic              step_end;

    assign step_end = (div_cnt == DIV_W'(SEQ_DIV - 1));

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt    <= '0;
            step       <= '0;
            len_tick   <= 1'b0;
            sweep_tick <= 1'b0;
            env_tick   <= 1'b0;
        end else begin
            div_cnt    <= step_end ? '0 : div_cnt + 1'b1;
            len_tick   <= step_end && LEN_STEPS[step];
            sweep_tick <= step_end && SWEEP_STEPS[step];
            env_tick   <= step_end && ENV_STEPS[step];
            if (step_end) begin
                step <= (step == STEP_W'(SEQ_STEPS - 1)) ? '0 : step + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* length_envelope.sv */
`timescale 1ns/1ps
`default_nettype none

module length_envelope (
    input  logic                                 system_clock,
    input  logic                                 arst_n,
    input  logic                                 trig,
    input  logic                                 len_tick,
    input  logic                                 env_tick,
    input  logic [apu_reg_pkg::LEN_W-1:0]        len_load,
    input  logic                                 len_en,
    input  logic [apu_reg_pkg::VOL_W-1:0]        env_init,
    input  logic                                 env_up,
    input  logic [apu_reg_pkg::ENV_PER_W-1:0]    env_period,
    output logic [apu_reg_pkg::VOL_W-1:0]        volume,
    output logic                                 len_expired
);
    import apu_reg_pkg::*;

    logic [LEN_W:0]       len_cnt;  // Holds 1 to 64.
    logic [ENV_PER_W-1:0] env_timer;

    assign len_expired = len_en && (len_cnt == '0);

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            len_cnt <= '0;
        end else if (trig) begin
            len_cnt <= (LEN_W+1)'(64) - {1'b0, len_load};
        end else if (len_tick && len_en && len_cnt != '0) begin
            len_cnt <= len_cnt - 1'b1;
        end
    end

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            env_timer <= '0;
            volume    <= '0;
        end else if (trig) begin
            env_timer <= env_period;
            volume    <= env_init;
        end else if (env_tick && env_period != '0) begin
            if (env_timer <= 1) begin
                env_timer <= env_period;
                if (env_up && volume != '1) begin
                    volume <= volume + 1'b1;
                end else if (!env_up && volume != '0) begin
                    volume <= volume - 1'b1;
                end
            end else begin
                env_timer <= env_timer - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* noise_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module noise_channel (
    input  logic                                 system_clock,
    input  logic                                 arst_n,
    input  logic                                 trig,
    input  logic                                 len_tick,
    input  logic                                 env_tick,
    input  logic [apu_reg_pkg::NZ_SHIFT_W-1:0]   shift,
    input  logic                                 width7,
    input  logic [apu_reg_pkg::NZ_DIV_W-1:0]     div,
    input  logic [apu_reg_pkg::LEN_W-1:0]        len_load,
    input  logic                                 len_en,
    input  logic [apu_reg_pkg::VOL_W-1:0]        env_init,
    input  logic                                 env_up,
    input  logic [apu_reg_pkg::ENV_PER_W-1:0]    env_period,
    output logic [apu_timing_pkg::LEVEL_W-1:0]   level,
    output logic                                 on
);
    import apu_reg_pkg::*;
    import apu_timing_pkg::*;

    logic [NZ_TMR_W-1:0] period;
    logic [NZ_TMR_W-1:0] timer;
    logic [14:0]         lfsr;
    logic [14:0]         lfsr_next;
    logic [VOL_W-1:0]    volume;
    logic                len_expired;

    length_envelope len_env_i (
        .system_clock(system_clock), .arst_n(arst_n), .trig(trig),
        .len_tick(len_tick), .env_tick(env_tick), .len_load(len_load),
        .len_en(len_en), .env_init(env_init), .env_up(env_up),
        .env_period(env_period), .volume(volume), .len_expired(len_expired)
    );

    assign period = (div == '0) ? NZ_TMR_W'(8) << shift : NZ_TMR_W'({div, 4'b0}) << shift;

    always_comb begin
        lfsr_next = {lfsr[0] ^ lfsr[1], lfsr[14:1]};
        if (width7) begin
            lfsr_next[6] = lfsr[0] ^ lfsr[1];  // Short 7-bit loop.
        end
    end

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            timer <= '0;
            lfsr  <= '1;
            on    <= 1'b0;
            level <= '0;
        end else begin
            level <= (on && !lfsr[0]) ? volume : '0;
            if (trig) begin
                timer <= period;
                lfsr  <= '1;
                on    <= 1'b1;
            end else begin
                if (timer <= 1) begin
                    timer <= period;
                    lfsr  <= lfsr_next;
                end else begin
                    timer <= timer - 1'b1;
                end
                if (len_expired) begin
                    on <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* square_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module square_channel (
    input  logic                                 system_clock,
    input  logic                                 arst_n,
    input  logic                                 trig,
    input  logic                                 len_tick,
    input  logic                                 sweep_tick,
    input  logic                                 env_tick,
    input  logic [apu_reg_pkg::FREQ_W-1:0]       freq,
    input  logic [apu_reg_pkg::DUTY_W-1:0]       duty,
    input  logic [apu_reg_pkg::SWP_W-1:0]        sweep_period,
    input  logic                                 sweep_down,
    input  logic [apu_reg_pkg::SWP_W-1:0]        sweep_shift,
    input  logic [apu_reg_pkg::LEN_W-1:0]        len_load,
    input  logic                                 len_en,
    input  logic [apu_reg_pkg::VOL_W-1:0]        env_init,
    input  logic                                 env_up,
    input  logic [apu_reg_pkg::ENV_PER_W-1:0]    env_period,
    output logic [apu_timing_pkg::LEVEL_W-1:0]   level,
    output logic                                 on
);
    import apu_reg_pkg::*;

    logic [FREQ_W-1:0] shadow;
    logic [FREQ_W:0]   timer;     // Holds up to 2048.
    logic [FREQ_W:0]   sweep_sum;
    logic [SWP_W-1:0]  sweep_timer;
    logic [2:0]        duty_pos;
    logic [7:0]        pattern;
    logic [VOL_W-1:0]  volume;
    logic              len_expired;
    logic              sweep_due;

    length_envelope len_env_i (
        .system_clock(system_clock), .arst_n(arst_n), .trig(trig),
        .len_tick(len_tick), .env_tick(env_tick), .len_load(len_load),
        .len_en(len_en), .env_init(env_init), .env_up(env_up),
        .env_period(env_period), .volume(volume), .len_expired(len_expired)
    );

    always_comb begin
        case (duty)
            2'd0:    pattern = 8'b0000_0001;  // 1 of 8.
            2'd1:    pattern = 8'b1000_0001;
            2'd2:    pattern = 8'b1000_0111;
            default: pattern = 8'b0111_1110;  // 6 of 8.
        endcase
    end

    assign sweep_sum = sweep_down ? {1'b0, shadow} - {1'b0, shadow >> sweep_shift}
                                  : {1'b0, shadow} + {1'b0, shadow >> sweep_shift};
    assign sweep_due = sweep_tick && sweep_period != '0 && sweep_timer <= 1;

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            {shadow, timer, sweep_timer, duty_pos} <= '0;
            on    <= 1'b0;
            level <= '0;
        end else begin
            level <= (on && pattern[duty_pos]) ? volume : '0;
            if (trig) begin
                shadow      <= freq;
                timer       <= (FREQ_W+1)'(2048) - {1'b0, freq};
                sweep_timer <= sweep_period;
                on          <= 1'b1;
            end else begin
                if (timer <= 1) begin
                    timer    <= (FREQ_W+1)'(2048) - {1'b0, shadow};
                    duty_pos <= duty_pos + 1'b1;
                end else begin
                    timer <= timer - 1'b1;
                end
                if (sweep_tick && sweep_period != '0) begin
                    sweep_timer <= sweep_due ? sweep_period : sweep_timer - 1'b1;
                end
                if (sweep_due && sweep_sum[FREQ_W]) begin
                    on <= 1'b0;  // Frequency overflow.
                end else if (sweep_due && sweep_shift != '0) begin
                    shadow <= sweep_sum[FREQ_W-1:0];
                end
                if (len_expired) begin
                    on <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_apu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apu;
    import apu_reg_pkg::*;
    import apu_timing_pkg::*;

    localparam int SEED    = 51022;
    localparam int MAX_P   = 40;    // Longest tone period used.
    localparam int WR      = 16;    // About eight register writes.
    localparam int NZ_WIN  = 2000;
    localparam int SUB_WIN = 500;
    localparam int FRAME   = SEQ_STEPS * SEQ_DIV;
    localparam int TEST_CYCLES = 12 + (WR + 10 * MAX_P) + (WR + 18 * SEQ_DIV)
        + (2 * WR + 9 * FRAME + 24 * MAX_P) + (WR + 4 * SEQ_DIV)
        + (4 * WR + NZ_WIN + 3 * SUB_WIN);
    localparam int CYCLE_LIMIT = TEST_CYCLES * 5 / 4;

    logic                system_clock = 1'b0;
    logic                arst_n = 1'b0;
    logic                wr_en = 1'b0;
    logic [ADDR_W-1:0]   wr_addr = '0;
    logic [DATA_W-1:0]   wr_data = '0;
    logic [SAMPLE_W-1:0] sample;
    logic                sq_on;
    logic                nz_on;

    int cycle_cnt = 0;
    bit mon_en = 1'b0;
    int exp_sq, exp_nz, exp_en, exp_mvol;
    int mon_cnt, sq_hi_cnt, nz_hi_cnt;
    int v_sq, v_nz, v_both;

    apu_top apu_top_i (
        .system_clock(system_clock), .arst_n(arst_n), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_data(wr_data), .sample(sample), .sq_on(sq_on), .nz_on(nz_on)
    );

    bind apu_top apu_chk chk_i (
        .system_clock(system_clock), .arst_n(arst_n), .sample(sample),
        .ch_enable(ch_enable), .sq_trig(sq_trig), .nz_trig(nz_trig),
        .len_tick(len_tick), .sweep_tick(sweep_tick), .env_tick(env_tick)
    );

    always #5 system_clock = ~system_clock;

    // Mixer rule: masked sum of levels, scaled by master volume plus one.
    function automatic int ref_sample(input int sq_level, input int nz_level,
                                      input int ch_enable, input int master_vol);
        int sum;
        sum = 0;
        if (ch_enable[0])
            sum += sq_level;
        if (ch_enable[1])
            sum += nz_level;
        return sum * (master_vol + 1);
    endfunction

    function automatic int duty_highs(input int duty);
        case (duty)
            0:       return 1;
            1:       return 2;
            2:       return 4;
            default: return 6;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: actual %0d, expected %0d", $time, name, actual,
                     expected);
            abort_run("Value mismatch.");
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge system_clock);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge system_clock);
        wr_en <= 1'b0;
    endtask

    task automatic trigger_square(input int freq, input bit len_en);
        write_reg(ADDR_NR13, freq[7:0]);
        write_reg(ADDR_NR14, {1'b1, len_en, 3'b000, freq[10:8]});
        @(posedge system_clock);
        @(negedge system_clock);
        check_value("sq_on", sq_on, 1);  // On two cycles after the strobe.
    endtask

    task automatic time_fall(input int limit, output int cycles);
        cycles = 0;
        while (sq_on) begin
            @(negedge system_clock);
            cycles++;
            if (cycles > limit)
                abort_run("sq_on stayed high past its limit.");
        end
    endtask

    task automatic monitor(input int cycles);
        @(posedge system_clock);
        mon_cnt   = 0;
        sq_hi_cnt = 0;
        nz_hi_cnt = 0;
        mon_en    = 1'b1;
        repeat (cycles) @(posedge system_clock);
        mon_en = 1'b0;
    endtask

    always @(posedge system_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT)
            abort_run("Timeout: the run went past its cycle limit.");
    end

    // Every sample must be one of the four level combinations.
    always @(negedge system_clock) begin
        if (mon_en) begin
            v_sq   = ref_sample(exp_sq, 0, exp_en, exp_mvol);
            v_nz   = ref_sample(0, exp_nz, exp_en, exp_mvol);
            v_both = ref_sample(exp_sq, exp_nz, exp_en, exp_mvol);
            check_value("sample_in_expected_set",
                        (sample == 0 || sample == v_sq || sample == v_nz || sample == v_both),
                        1);
            mon_cnt++;
            if (v_sq != 0 && (sample == v_sq || sample == v_both))
                sq_hi_cnt++;
            if (v_nz != 0 && (sample == v_nz || sample == v_both))
                nz_hi_cnt++;
        end
    end

    always @(negedge system_clock) begin
        if (apu_top_i.chk_i.fail_cnt != 0)
            abort_run("A concurrent assertion on apu_top failed.");
    end

    initial begin
        int per;
        int freq;
        int duty;
        int vol;
        int mvol;
        int len;
        int cycles;
        int peak;
        void'($urandom(SEED));
        repeat (10) @(posedge system_clock);
        arst_n <= 1'b1;
        @(negedge system_clock);
        check_value("sample", sample, 0);
        check_value("sq_on", sq_on, 0);
        check_value("nz_on", nz_on, 0);

        per  = $urandom_range(MAX_P, 4);
        freq = 2048 - per;
        duty = $urandom_range(3, 0);
        vol  = $urandom_range(15, 1);
        mvol = $urandom_range(7, 0);
        write_reg(ADDR_NR50, 8'(mvol));
        write_reg(ADDR_NR51, 8'h01);  // Square only.
        write_reg(ADDR_NR12, 8'(vol << 4));
        write_reg(ADDR_NR11, 8'(duty << 6));
        trigger_square(freq, 1'b0);
        exp_sq   = vol;
        exp_nz   = 0;
        exp_en   = 1;
        exp_mvol = mvol;
        repeat (2 * per + 4) @(posedge system_clock);
        monitor(8 * per);
        check_value("duty_high_cycles", sq_hi_cnt, duty_highs(duty) * per);

        len = $urandom_range(63, 56);
        write_reg(ADDR_NR11, 8'((duty << 6) | len));
        trigger_square(freq, 1'b1);
        time_fall((65 - len) * 2 * SEQ_DIV, cycles);
        if (cycles < (63 - len) * 2 * SEQ_DIV)
            abort_run("sq_on fell before the length count ran out.");
        repeat (4) @(negedge system_clock);
        check_value("sample", sample, 0);

        vol = $urandom_range(4, 1);
        write_reg(ADDR_NR12, 8'((vol << 4) | 1));  // Decrease, period 1.
        trigger_square(freq, 1'b0);
        repeat ((vol + 1) * FRAME) @(negedge system_clock);
        repeat (8 * per) begin
            @(negedge system_clock);
            check_value("sample", sample, 0);
            check_value("sq_on", sq_on, 1);
        end

        vol = $urandom_range(14, 12);
        write_reg(ADDR_NR12, 8'((vol << 4) | 9));  // Increase, period 1.
        trigger_square(freq, 1'b0);
        peak = 0;
        repeat ((16 - vol) * FRAME + 16 * per) begin
            @(negedge system_clock);
            if (sample > peak)
                peak = sample;
        end
        check_value("peak_sample", peak, ref_sample(15, 0, 1, mvol));

        write_reg(ADDR_NR10, 8'h11);  // Period 1, increase, shift 1.
        trigger_square($urandom_range(2047, 2000), 1'b0);
        time_fall(4 * SEQ_DIV + 2, cycles);
        write_reg(ADDR_NR10, 8'h00);

        vol    = $urandom_range(15, 1);
        exp_nz = (vol + $urandom_range(14, 1) - 1) % 15 + 1;  // Never equal to vol.
        mvol   = $urandom_range(7, 0);
        write_reg(ADDR_NR12, 8'(vol << 4));
        write_reg(ADDR_NR42, 8'(exp_nz << 4));
        write_reg(ADDR_NR43, {4'd0, 1'($urandom_range(1, 0)), 3'($urandom_range(1, 0))});
        write_reg(ADDR_NR44, 8'h80);
        write_reg(ADDR_NR50, 8'(mvol));
        write_reg(ADDR_NR51, 8'h03);
        trigger_square(2048 - per, 1'b0);
        exp_sq   = vol;
        exp_en   = 3;
        exp_mvol = mvol;
        repeat (4) @(posedge system_clock);
        monitor(NZ_WIN);
        check_value("noise_high_seen", nz_hi_cnt > 0, 1);
        check_value("noise_low_seen", nz_hi_cnt < mon_cnt, 1);
        check_value("nz_on", nz_on, 1);

        for (int en = 2; en >= 0; en--) begin
            write_reg(ADDR_NR51, 8'(en));
            exp_en = en;
            repeat (4) @(posedge system_clock);
            monitor(SUB_WIN);
        end

        if (apu_top_i.chk_i.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("Concurrent assertions on apu_top failed.");
        end
    end

endmodule

`default_nettype wire
